//--- flist.f
logic/mac_axis_pkg.sv
logic/word_fifo.sv
logic/tx_packer.sv
logic/rx_length_queue.sv
logic/rx_credit_counter.sv
logic/rx_read_fsm.sv
logic/mac_axis.sv
bench/tb_clkgen.sv
bench/mac_axis_asserts.sv
bench/mac_axis_tb.sv

//--- Makefile
SIM    = verilator
TOP    = mac_axis_tb
FLIST  = flist.f
FLAGS  = --binary --timing --assert -Wno-fatal -j 0
OBJDIR = obj_dir
BIN    = $(OBJDIR)/V$(TOP)
LOG    = sim.log
SRCS   = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- bench/mac_axis_tb.sv
`timescale 1ns/10ps

module mac_axis_tb;

	import mac_axis_pkg::*;

	localparam int TX_PKTS = 12;
	localparam int RX_PKTS = 16;
	// two tests per direction, 40 cycles per packet
	localparam int LIMIT = 40 * (2 * TX_PKTS + 2 * RX_PKTS) + 200;
	localparam int RX_DEPTH = 16;

	logic              clk;
	logic              rst;
	logic              append_crc;
	user_beat_t        tx_beat;
	logic              tx_valid;
	logic              tx_ready;
	mac_word_t         tx_word;
	logic              tx_wr;
	logic              tx_wa;
	logic              rx_rd;
	mac_word_t         rx_word;
	logic              rx_pa;
	logic              rx_len_valid;
	logic [LEN_W-1:0]  rx_len;
	rx_status_t        rx_status;
	user_beat_t        rx_beat;
	logic [LEN_W-1:0]  rx_tuser;
	logic              rx_valid;
	logic              rx_tready;

	logic [31:0]       seed = 32'h2285b34a;
	int unsigned       cyc = 0;
	int                errors = 0;
	int                tests = 0;
	int                failed = 0;

	// scoreboards
	mac_word_t         tx_exp[$];
	user_beat_t        rx_exp[$];
	logic [LEN_W-1:0]  tuser_exp[$];

	// MAC model state
	mac_word_t         mac_q[$];
	int                ok_n[$];
	mac_word_t         ret_word[$];
	int unsigned       ret_time[$];
	int unsigned       last_ret = 0;
	int                srv_idx = 0;
	int                reported_ok = 0;
	int                pending_ok = 0;
	int                cur_left = 0;
	int                ignored_cnt = 0;
	bit                pkt_open = 0;
	int                tb_cred = RX_DEPTH;

	// handshake shaping
	bit                wa_mode = 0;
	bit                wa_low = 0;
	int                wa_run = 0;
	bit                rdy_mode = 0;
	bit                saw_full = 0;
	bit                saw_dry = 0;

	tb_clkgen clkgen_i (
		.clk (clk),
		.rst (rst)
	);

	mac_axis #(
		.TX_AW  (4),
		.RX_AW  (4),
		.LEN_AW (3)
	) mac_axis_i (
		.Rst_rx         (clk),
		.MAC_rx_clk_div (rst),
		.append_crc     (append_crc),
		.tx_beat        (tx_beat),
		.tx_valid       (tx_valid),
		.tx_ready       (tx_ready),
		.tx_word        (tx_word),
		.tx_wr          (tx_wr),
		.tx_wa          (tx_wa),
		.rx_rd          (rx_rd),
		.rx_word        (rx_word),
		.rx_pa          (rx_pa),
		.rx_len_valid   (rx_len_valid),
		.rx_len         (rx_len),
		.rx_status      (rx_status),
		.rx_beat        (rx_beat),
		.rx_tuser       (rx_tuser),
		.rx_valid       (rx_valid),
		.rx_tready      (rx_tready)
	);

	bind rx_credit_counter mac_axis_asserts #(.DEPTH(DEPTH), .CW(CW)) asserts_i (
		.Rst_rx         (Rst_rx),
		.MAC_rx_clk_div (MAC_rx_clk_div),
		.spend          (spend),
		.credit_avail   (credit_avail),
		.release_count  (release_count),
		.credits        (credits)
	);

	// ******************************
	// helpers
	// ******************************

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = lcg_next();
		return lo + (int'({8'd0, r[31:8]}) % (hi - lo + 1));
	endfunction

	// top-aligned masks only, rest counts as a full word
	function automatic be_t keep_to_be(input logic [3:0] keep);
		if (keep == 4'b1110)
			return BE_THREE;
		if (keep == 4'b1100)
			return BE_TWO;
		if (keep == 4'b1000)
			return BE_ONE;
		return BE_FOUR;
	endfunction

	function automatic logic [3:0] be_to_keep(input be_t be);
		if (be == BE_ONE)
			return 4'b1000;
		if (be == BE_TWO)
			return 4'b1100;
		if (be == BE_THREE)
			return 4'b1110;
		return 4'b1111;
	endfunction

	function automatic int be_bytes(input be_t be);
		return (be == BE_FOUR) ? 4 : int'(be);
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
	                           input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s got %0h expected %0h",
			         $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic report_error(input string what);
		$display("error at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		if (errors > err0)
			failed++;
		$display("test %s: %0d errors", name, errors - err0);
	endtask

	// ******************************
	// cycle count and watchdog
	// ******************************

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc > LIMIT) begin
			$display("timeout after %0d cycles, the run did not finish", cyc);
			$display("Something failed");
			$finish;
		end
	end

	// ******************************
	// MAC side drivers
	// ******************************

	always @(posedge clk) begin
		#2;
		// tx_wa in runs of high and low when throttled
		if (!wa_mode) begin
			tx_wa = 1'b1;
		end else begin
			if (wa_run == 0) begin
				wa_low = !wa_low;
				wa_run = rand_range(1, 24);
			end
			wa_run--;
			tx_wa = !wa_low;
		end
		// ready one cycle in four when stalling
		rx_tready = rdy_mode ? (rand_range(0, 3) == 0) : 1'b1;
		// return scheduled words in order
		if (ret_time.size() > 0 && ret_time[0] == cyc) begin
			rx_pa = 1'b1;
			rx_word = ret_word.pop_front();
			void'(ret_time.pop_front());
		end else begin
			rx_pa = 1'b0;
		end
	end

	// ******************************
	// monitors, sampled mid cycle
	// ******************************

	always @(negedge clk) begin
		int unsigned t;
		if (!rst) begin
			if (tx_valid && !tx_ready)
				saw_full = 1'b1;
			// credits used up at least once
			if (tb_cred == 0)
				saw_dry = 1'b1;
			// transmit words
			if (tx_wr) begin
				if (tx_exp.size() == 0)
					report_error("transmit word appeared with nothing expected");
				else
					check_value(64'(tx_word), 64'(tx_exp.pop_front()), "tx_word");
			end
			// read requests, judged on the count before this cycle's returns
			if (rx_rd) begin
				if (tb_cred <= 0)
					report_error("read request arrived while no credit was left");
				tb_cred--;
				if (!pkt_open) begin
					if (srv_idx >= reported_ok) begin
						report_error("read request before any packet was reported");
					end else begin
						pkt_open = 1;
						cur_left = ok_n[srv_idx];
						srv_idx++;
					end
				end
				if (pkt_open && cur_left > 0) begin
					t = cyc + rand_range(1, 4);
					if (t <= last_ret)
						t = last_ret + 1;
					last_ret = t;
					ret_time.push_back(t);
					ret_word.push_back(mac_q.pop_front());
					cur_left--;
				end else if (pkt_open) begin
					ignored_cnt++;
				end
			end
			// receive beats
			if (rx_valid && rx_tready) begin
				tb_cred++;
				if (rx_exp.size() == 0) begin
					report_error("receive beat appeared with nothing expected");
				end else begin
					check_value(64'(rx_beat), 64'(rx_exp.pop_front()), "rx_beat");
					check_value(64'(rx_tuser), 64'(tuser_exp.pop_front()), "rx_tuser");
				end
				if (rx_beat.tlast)
					pending_ok--;
			end
			// eop returned, dropped requests come back as credits
			if (rx_pa && rx_word.eop) begin
				tb_cred += ignored_cnt;
				ignored_cnt = 0;
				pkt_open = 0;
			end
		end
	end

	// ******************************
	// tests
	// ******************************

	task automatic check_reset();
		int err0;
		err0 = errors;
		@(negedge clk);
		while (rst) begin
			check_value(64'(tx_ready), 64'(0), "tx_ready in reset");
			check_value(64'(tx_wr), 64'(0), "tx_wr in reset");
			check_value(64'(rx_rd), 64'(0), "rx_rd in reset");
			check_value(64'(rx_valid), 64'(0), "rx_valid in reset");
			@(negedge clk);
		end
		// first cycle after release
		check_value(64'(tx_ready), 64'(0), "tx_ready after reset");
		check_value(64'(tx_wr), 64'(0), "tx_wr after reset");
		check_value(64'(rx_rd), 64'(0), "rx_rd after reset");
		check_value(64'(rx_valid), 64'(0), "rx_valid after reset");
		end_test("reset_state", err0);
	endtask

	task automatic run_tx(input int npkt, input bit throttle, input string name);
		int err0;
		int nb;
		logic [3:0] keep;
		mac_word_t w;
		err0 = errors;
		wa_mode = throttle;
		saw_full = 0;
		@(posedge clk);
		#2;
		for (int p = 0; p < npkt; p++) begin
			nb = rand_range(1, 20);
			for (int b = 0; b < nb; b++) begin
				keep = (b == nb - 1) ? 4'(rand_range(0, 15)) : 4'hf;
				tx_beat.tdata = lcg_next();
				tx_beat.tkeep = keep;
				tx_beat.tlast = (b == nb - 1);
				tx_valid = 1'b1;
				w.sop = (b == 0);
				w.eop = (b == nb - 1);
				w.be = keep_to_be(keep);
				w.data = tx_beat.tdata;
				tx_exp.push_back(w);
				// hold the beat until it is taken
				@(negedge clk);
				while (!tx_ready)
					@(negedge clk);
				@(posedge clk);
				#2;
				tx_valid = 1'b0;
				// idle gaps only without throttling
				if (!throttle && rand_range(0, 3) == 0) begin
					repeat (rand_range(1, 3)) @(posedge clk);
					#2;
				end
			end
		end
		while (tx_exp.size() > 0)
			@(negedge clk);
		wa_mode = 0;
		if (throttle && !saw_full)
			report_error("transmit FIFO never filled, tx_ready stayed high");
		end_test(name, err0);
	endtask

	task automatic run_rx(input int npkt, input bit crc_in, input bit stall,
	                      input string name);
		int err0;
		int nw;
		int bytes;
		be_t be;
		rx_status_t st;
		logic [LEN_W-1:0] len;
		logic [LEN_W-1:0] tu;
		mac_word_t mw;
		user_beat_t ub;
		err0 = errors;
		append_crc = crc_in;
		rdy_mode = stall;
		saw_dry = 0;
		@(posedge clk);
		#2;
		for (int p = 0; p < npkt; p++) begin
			// long packets outgrow the receive FIFO
			nw = rand_range(1, 32);
			be = be_t'(rand_range(0, 3));
			bytes = (nw - 1) * 4 + be_bytes(be);
			len = LEN_W'(bytes + CRC_BYTES);
			case (rand_range(0, 5))
				0: st = RX_CRC_ERR;
				1: st = RX_LEN_ERR;
				2: st = RX_RUNT;
				default: st = RX_OK;
			endcase
			if (st == RX_OK) begin
				tu = crc_in ? len : len - LEN_W'(CRC_BYTES);
				for (int w = 0; w < nw; w++) begin
					mw.sop = (w == 0);
					mw.eop = (w == nw - 1);
					mw.be = (w == nw - 1) ? be : BE_FOUR;
					mw.data = lcg_next();
					mac_q.push_back(mw);
					ub.tdata = mw.data;
					ub.tkeep = be_to_keep(mw.be);
					ub.tlast = mw.eop;
					rx_exp.push_back(ub);
					tuser_exp.push_back(tu);
				end
				ok_n.push_back(nw);
				// keep the length FIFO from overflowing
				while (pending_ok >= 6) begin
					@(posedge clk);
					#2;
				end
				pending_ok++;
				reported_ok++;
			end
			rx_len_valid = 1'b1;
			rx_len = len;
			rx_status = st;
			repeat (rand_range(1, 3)) @(posedge clk);
			#2;
			rx_len_valid = 1'b0;
			rx_status = RX_OK;
			repeat (rand_range(1, 3)) @(posedge clk);
			#2;
		end
		while (rx_exp.size() > 0 || pending_ok > 0)
			@(negedge clk);
		rdy_mode = 0;
		if (stall && !saw_dry)
			report_error("receive credits never ran out, rx_rd was never held back");
		end_test(name, err0);
	endtask

	initial begin
		append_crc = 1'b0;
		tx_beat = '0;
		tx_valid = 1'b0;
		tx_wa = 1'b1;
		rx_word = '0;
		rx_pa = 1'b0;
		rx_len_valid = 1'b0;
		rx_len = '0;
		rx_status = RX_OK;
		rx_tready = 1'b1;

		check_reset();
		run_tx(TX_PKTS, 1'b0, "tx_framing");
		run_tx(TX_PKTS, 1'b1, "tx_backpressure");
		run_rx(RX_PKTS, 1'b0, 1'b0, "rx_data_keep_length");
		run_rx(RX_PKTS, 1'b1, 1'b1, "rx_append_crc_backpressure");
		repeat (5) @(posedge clk);

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- bench/mac_axis_asserts.sv
`timescale 1ns/10ps

module mac_axis_asserts #(
	parameter int DEPTH = 16,
	parameter int CW = 5
) (
	input logic          Rst_rx,
	input logic          MAC_rx_clk_div,
	input logic          spend,
	input logic          credit_avail,
	input logic          release_count,
	input logic [CW-1:0] credits
);

	// no read request without a free slot behind it
	a_rd_needs_credit: assert property (@(posedge Rst_rx) disable iff (MAC_rx_clk_div)
		spend |-> credit_avail)
		else $error("read request issued with no credit");

	// counter never above the FIFO depth
	a_credit_bound: assert property (@(posedge Rst_rx) disable iff (MAC_rx_clk_div)
		credits <= CW'(DEPTH))
		else $error("credit count above FIFO depth");

	// end of packet pulses never back to back
	a_burst_gap: assert property (@(posedge Rst_rx) disable iff (MAC_rx_clk_div)
		release_count |=> !release_count)
		else $error("burst_done pulsed on consecutive cycles");

endmodule

//--- bench/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk,
	output logic rst
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held for three rising edges
	// released just after the edge like other stimulus
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
	end

endmodule

//--- logic/mac_axis.sv
`timescale 1ns/10ps

module mac_axis #(
	parameter int TX_AW = 4,
	parameter int RX_AW = 4,
	parameter int LEN_AW = 3
) (
	input  logic                           Rst_rx,
	input  logic                           MAC_rx_clk_div,
	// keep FCS bytes in the reported length
	input  logic                           append_crc,
	// transmit user side
	input  mac_axis_pkg::user_beat_t       tx_beat,
	input  logic                           tx_valid,
	output logic                           tx_ready,
	// transmit MAC side
	output mac_axis_pkg::mac_word_t        tx_word,
	output logic                           tx_wr,
	input  logic                           tx_wa,
	// receive MAC read path
	output logic                           rx_rd,
	input  mac_axis_pkg::mac_word_t        rx_word,
	input  logic                           rx_pa,
	// receive MAC length report
	input  logic                           rx_len_valid,
	input  logic [mac_axis_pkg::LEN_W-1:0] rx_len,
	input  mac_axis_pkg::rx_status_t       rx_status,
	// receive user side
	output mac_axis_pkg::user_beat_t       rx_beat,
	output logic [mac_axis_pkg::LEN_W-1:0] rx_tuser,
	output logic                           rx_valid,
	input  logic                           rx_tready
);

	import mac_axis_pkg::*;

	mac_word_t         rx_head;
	logic              rx_empty;
	logic              rx_pop;
	logic [KEEP_W-1:0] rx_keep;
	logic              len_pop;
	logic              len_ready;
	logic              credit_avail;
	logic              burst_done;

	// ******************************
	// transmit
	// ******************************

	tx_packer #(.AW(TX_AW)) tx_packer_i (
		.Rst_rx         (Rst_rx),
		.MAC_rx_clk_div (MAC_rx_clk_div),
		.tx_beat        (tx_beat),
		.tx_valid       (tx_valid),
		.tx_ready       (tx_ready),
		.tx_word        (tx_word),
		.tx_wr          (tx_wr),
		.tx_wa          (tx_wa)
	);

	// ******************************
	// receive
	// ******************************

	// length shown on tuser for the whole packet
	rx_length_queue #(.AW(LEN_AW)) len_queue_i (
		.Rst_rx         (Rst_rx),
		.MAC_rx_clk_div (MAC_rx_clk_div),
		.rx_len_valid   (rx_len_valid),
		.rx_len         (rx_len),
		.rx_status      (rx_status),
		.append_crc     (append_crc),
		.len_pop        (len_pop),
		.len_head       (rx_tuser),
		.len_ready      (len_ready)
	);

	// one credit per receive FIFO slot
	rx_credit_counter #(.DEPTH(1 << RX_AW)) credit_i (
		.Rst_rx         (Rst_rx),
		.MAC_rx_clk_div (MAC_rx_clk_div),
		.spend          (rx_rd),
		.refund         (rx_pop),
		.arrive         (rx_pa),
		.release_count  (burst_done),
		.credit_avail   (credit_avail)
	);

	rx_read_fsm read_fsm_i (
		.Rst_rx         (Rst_rx),
		.MAC_rx_clk_div (MAC_rx_clk_div),
		.len_ready      (len_ready),
		.len_pop        (len_pop),
		.credit_avail   (credit_avail),
		.rx_pa          (rx_pa),
		.rx_eop         (rx_word.eop),
		.rx_rd          (rx_rd),
		.burst_done     (burst_done)
	);

	// credits rule out overflow, full is not watched
	word_fifo #(
		.WIDTH ($bits(mac_word_t)),
		.AW    (RX_AW)
	) rx_fifo_i (
		.clk   (Rst_rx),
		.rst   (MAC_rx_clk_div),
		.push  (rx_pa),
		.din   (rx_word),
		.pop   (rx_pop),
		.dout  (rx_head),
		.empty (rx_empty),
		.full  ()
	);

	assign rx_valid = !rx_empty;
	assign rx_pop   = rx_valid && rx_tready;
	// length entry leaves with the last beat
	assign len_pop  = rx_pop && rx_head.eop;

	// byte enable back to a top-aligned keep mask
	always_comb begin
		case (rx_head.be)
			BE_ONE:   rx_keep = 4'b1000;
			BE_TWO:   rx_keep = 4'b1100;
			BE_THREE: rx_keep = 4'b1110;
			default:  rx_keep = 4'b1111;
		endcase
	end

	assign rx_beat = '{tdata: rx_head.data, tkeep: rx_keep, tlast: rx_head.eop};

endmodule

//--- logic/rx_read_fsm.sv
`timescale 1ns/10ps

module rx_read_fsm (
	input  logic Rst_rx,
	input  logic MAC_rx_clk_div,
	// a good packet length is queued
	input  logic len_ready,
	// length entry consumed with the last beat
	input  logic len_pop,
	input  logic credit_avail,
	// returned MAC word strobe and its eop bit
	input  logic rx_pa,
	input  logic rx_eop,
	output logic rx_rd,
	output logic burst_done
);

	import mac_axis_pkg::*;

	rd_state_t state;
	// started packet whose length is still at the queue head
	logic      len_held;
	logic      eop_seen;

	assign eop_seen = rx_pa && rx_eop;

	// one pulse per packet, then the gap state
	assign burst_done = (state == RD_BURST) && eop_seen;

	// one word per credit while bursting
	// nothing asked on the cycle the packet ends
	assign rx_rd = (state == RD_BURST) && credit_avail && !eop_seen;

	// ******************************
	// read sequencing
	// ******************************

	always_ff @(posedge Rst_rx or posedge MAC_rx_clk_div) begin
		if (MAC_rx_clk_div) begin
			state    <= RD_IDLE;
			len_held <= 1'b0;
		end else begin
			// previous packet fully delivered
			if (len_pop)
				len_held <= 1'b0;
			case (state)
				RD_IDLE: begin
					// head entry must belong to a new packet
					if (len_ready && !len_held) begin
						state    <= RD_BURST;
						len_held <= 1'b1;
					end
				end
				RD_BURST: begin
					if (eop_seen)
						state <= RD_GAP;
				end
				// single dead cycle between packets
				RD_GAP: begin
					state <= RD_IDLE;
				end
				default: begin
					state <= RD_IDLE;
				end
			endcase
		end
	end

endmodule

//--- logic/rx_credit_counter.sv
`timescale 1ns/10ps

module rx_credit_counter #(
	parameter int DEPTH = 16
) (
	input  logic Rst_rx,
	input  logic MAC_rx_clk_div,
	// read request issued to the MAC
	input  logic spend,
	// word popped by the user
	input  logic refund,
	// requested word landed in the receive FIFO
	input  logic arrive,
	// end of packet seen by the read FSM
	input  logic release_count,
	output logic credit_avail
);

	localparam int CW = $clog2(DEPTH + 1);

	// free FIFO slots minus requests in flight
	logic [CW-1:0] credits;
	// requests issued and not yet answered
	logic [CW-1:0] outstanding;
	// requests the MAC will drop after eop
	logic [CW-1:0] ignored;

	// the eop word itself answers one request
	assign ignored = outstanding - CW'(arrive);

	// single decision point for issuing reads
	assign credit_avail = (credits != '0);

	always_ff @(posedge Rst_rx or posedge MAC_rx_clk_div) begin
		if (MAC_rx_clk_div) begin
			credits     <= CW'(DEPTH);
			outstanding <= '0;
		end else begin
			// arrival moves a slot from in flight to occupied
			// so it leaves credits as they are
			credits <= credits - CW'(spend) + CW'(refund) +
			           (release_count ? ignored : '0);
			if (release_count)
				outstanding <= '0;
			else
				outstanding <= outstanding + CW'(spend) - CW'(arrive);
		end
	end

endmodule

//--- logic/rx_length_queue.sv
`timescale 1ns/10ps

module rx_length_queue #(
	parameter int AW = 3
) (
	input  logic                           Rst_rx,
	input  logic                           MAC_rx_clk_div,
	// MAC end-of-packet report
	input  logic                           rx_len_valid,
	input  logic [mac_axis_pkg::LEN_W-1:0] rx_len,
	input  mac_axis_pkg::rx_status_t       rx_status,
	input  logic                           append_crc,
	// consumer side
	input  logic                           len_pop,
	output logic [mac_axis_pkg::LEN_W-1:0] len_head,
	output logic                           len_ready
);

	import mac_axis_pkg::*;

	// last sampled report level
	logic             valid_d;
	logic             rise;
	logic             push_q;
	logic [LEN_W-1:0] len_adj;
	logic [LEN_W-1:0] len_q;
	logic             len_empty;

	// report is a level, one entry per rising edge
	assign rise = rx_len_valid && !valid_d;

	// FCS stays counted only when it is kept in the data
	assign len_adj = append_crc ? rx_len : rx_len - LEN_W'(CRC_BYTES);

	// edge detect and qualify
	always_ff @(posedge Rst_rx or posedge MAC_rx_clk_div) begin
		if (MAC_rx_clk_div) begin
			valid_d <= 1'b0;
			push_q  <= 1'b0;
		end else begin
			valid_d <= rx_len_valid;
			// bad frames are never read, so never queued
			push_q  <= rise && (rx_status == RX_OK);
		end
	end

	// length captured alongside the push strobe
	always_ff @(posedge Rst_rx) begin
		if (rise)
			len_q <= len_adj;
	end

	word_fifo #(
		.WIDTH (LEN_W),
		.AW    (AW)
	) len_fifo_i (
		.clk   (Rst_rx),
		.rst   (MAC_rx_clk_div),
		.push  (push_q),
		.din   (len_q),
		.pop   (len_pop),
		.dout  (len_head),
		.empty (len_empty),
		.full  ()
	);

	assign len_ready = !len_empty;

endmodule

//--- logic/tx_packer.sv
`timescale 1ns/10ps

module tx_packer #(
	parameter int AW = 4
) (
	input  logic                     Rst_rx,
	input  logic                     MAC_rx_clk_div,
	// user side
	input  mac_axis_pkg::user_beat_t tx_beat,
	input  logic                     tx_valid,
	output logic                     tx_ready,
	// MAC side
	output mac_axis_pkg::mac_word_t  tx_word,
	output logic                     tx_wr,
	input  logic                     tx_wa
);

	import mac_axis_pkg::*;

	// held low through reset, opens the user side one cycle later
	logic      ready_en;
	// high between the first and last beat of a packet
	logic      in_pkt;
	logic      accept;
	logic      fifo_full;
	logic      fifo_empty;
	be_t       be;
	mac_word_t push_word;

	assign tx_ready = ready_en && !fifo_full;
	assign accept   = tx_valid && tx_ready;

	// ******************************
	// keep to byte enable
	// ******************************

	// only top-aligned partial masks have a code
	// anything else goes out as a full word
	always_comb begin
		case (tx_beat.tkeep)
			4'b1110: be = BE_THREE;
			4'b1100: be = BE_TWO;
			4'b1000: be = BE_ONE;
			default: be = BE_FOUR;
		endcase
	end

	// sop from the packet flag, eop straight from tlast
	always_comb begin
		push_word.sop  = !in_pkt;
		push_word.eop  = tx_beat.tlast;
		push_word.be   = be;
		push_word.data = tx_beat.tdata;
	end

	// packet tracking
	always_ff @(posedge Rst_rx or posedge MAC_rx_clk_div) begin
		if (MAC_rx_clk_div) begin
			ready_en <= 1'b0;
			in_pkt   <= 1'b0;
		end else begin
			ready_en <= 1'b1;
			// single-beat packet leaves the flag clear
			if (accept)
				in_pkt <= !tx_beat.tlast;
		end
	end

	// ******************************
	// transmit FIFO
	// ******************************

	word_fifo #(
		.WIDTH ($bits(mac_word_t)),
		.AW    (AW)
	) tx_fifo_i (
		.clk   (Rst_rx),
		.rst   (MAC_rx_clk_div),
		.push  (accept),
		.din   (push_word),
		.pop   (tx_wr),
		.dout  (tx_word),
		.empty (fifo_empty),
		.full  (fifo_full)
	);

	// MAC takes a word on every cycle it is offered and accepted
	assign tx_wr = !fifo_empty && tx_wa;

endmodule

//--- logic/word_fifo.sv
`timescale 1ns/10ps

module word_fifo #(
	parameter int WIDTH = 36,
	parameter int AW = 4
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic [WIDTH-1:0] din,
	input  logic             pop,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             full
);

	localparam int DEPTH = 1 << AW;

	// register array storage
	logic [WIDTH-1:0] mem [DEPTH];
	// pointers carry one extra wrap bit
	logic [AW:0]      wr_ptr;
	logic [AW:0]      rd_ptr;
	logic             do_push;
	logic             do_pop;

	// qualified strobes, overflow and underflow requests dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// same address and same wrap bit means nothing stored
	assign empty = (wr_ptr == rd_ptr);
	// same address, wrap bits differ
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
	               (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// first word fall through
	// head is shown as soon as it is written
	assign dout = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// write port
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= din;
	end

endmodule

//--- logic/mac_axis_pkg.sv
package mac_axis_pkg;

	// ******************************
	// widths
	// ******************************

	// user and MAC data word
	localparam int DATA_W = 32;
	// one keep bit per byte lane
	localparam int KEEP_W = 4;
	// packet length as reported by the MAC
	localparam int LEN_W = 16;
	// trailing FCS bytes
	localparam int CRC_BYTES = 4;

	// ******************************
	// encodings
	// ******************************

	// valid byte count of a last word, packed from the top lane down
	typedef enum logic [1:0] {
		BE_FOUR  = 2'd0,
		BE_ONE   = 2'd1,
		BE_TWO   = 2'd2,
		BE_THREE = 2'd3
	} be_t;

	// MAC receive report, only good frames get queued
	typedef enum logic [2:0] {
		RX_OK      = 3'd0,
		RX_CRC_ERR = 3'd1,
		RX_LEN_ERR = 3'd2,
		RX_RUNT    = 3'd3
	} rx_status_t;

	// receive read sequencer
	typedef enum logic [1:0] {
		RD_IDLE  = 2'd0,
		RD_BURST = 2'd1,
		RD_GAP   = 2'd2
	} rd_state_t;

	// ******************************
	// grouped signals
	// ******************************

	// MAC word, also the FIFO entry
	typedef struct packed {
		logic              sop;
		logic              eop;
		be_t               be;
		logic [DATA_W-1:0] data;
	} mac_word_t;

	// user stream beat
	typedef struct packed {
		logic [DATA_W-1:0] tdata;
		logic [KEEP_W-1:0] tkeep;
		logic              tlast;
	} user_beat_t;

endpackage
